/* common/upPkg.sv */
package upPkg;

	typedef logic [7:0] byteT;
	typedef logic [7:0] addrT;

	// Opcode byte of a two-byte instruction
	typedef enum logic [7:0] {
		LDI = 8'h10,
		LDA = 8'h20,
		STA = 8'h30,
		ADD = 8'h40,
		SUB = 8'h50,
		AND = 8'h60,
		JMP = 8'h70,
		JZ  = 8'h80,
		HLT = 8'hF0
	} opcodeT;

	typedef enum logic [1:0] {
		HALTED,
		FETCH,
		OPERAND,
		EXECUTE
	} coreStateT;

	typedef struct packed {
		addrT addr;
		byteT wdata;
		logic we;
	} memReqT;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [8:0]  paddr;
		logic [31:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRspT;

	// Host register offsets above the memory window
	localparam logic [8:0] regAddrCtrl   = 9'h100;
	localparam logic [8:0] regAddrStatus = 9'h104;

endpackage

/* hdl/upMemory.sv */
`timescale 1ns/1ps

module upMemory import upPkg::*; #(
	parameter addrT portAddr = 8'd127
) (
	input  logic   clk,
	input  logic   nRst,
	input  memReqT hostReq,
	input  memReqT coreReq,
	input  logic   hostOwn,
	output byteT   rdata,
	output byteT   portOut
);

	byteT   mem [256];
	memReqT req;

	// The host owns the memory whenever the core is halted
	assign req = hostOwn ? hostReq : coreReq;

	assign rdata   = mem[req.addr];
	assign portOut = mem[portAddr];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= 8'h00;
			end
			// Boot image writes 0x5A to the output port and halts
			mem[0] <= LDI;
			mem[1] <= 8'h5A;
			mem[2] <= STA;
			mem[3] <= portAddr;
			mem[4] <= HLT;
			mem[5] <= 8'h00;
		end else if (req.we) begin
			mem[req.addr] <= req.wdata;
		end
	end

	// A running core never shares the port with the host
	coreWriteOnlyWhenRunning: assert property (
		@(posedge clk) disable iff (!nRst)
		hostOwn |-> !coreReq.we
	) else $error("core write while host owns memory");

endmodule

/* core/upCore.sv */
`timescale 1ns/1ps

module upCore import upPkg::*; (
	input  logic   clk,
	input  logic   nRst,
	input  logic   start,
	input  byteT   rdata,
	output memReqT coreReq,
	output logic   halted,
	output byteT   acc,
	output logic   zero,
	output addrT   pc
);

	coreStateT state;
	opcodeT    opcode;
	byteT      operand;
	byteT      accNext;
	logic      accWrite;

	assign halted = (state == HALTED);

	// Memory request for the current phase
	always_comb begin
		coreReq.addr  = pc;
		coreReq.wdata = acc;
		coreReq.we    = 1'b0;
		case (state)
			OPERAND: coreReq.addr = addrT'(pc + 8'd1);
			EXECUTE: begin
				coreReq.addr = operand;
				coreReq.we   = (opcode == STA);
			end
			default: coreReq.addr = pc;
		endcase
	end

	// Accumulator result from mem[operand], which rdata holds in EXECUTE
	always_comb begin
		accNext  = acc;
		accWrite = 1'b1;
		case (opcode)
			LDI:     accNext = operand;
			LDA:     accNext = rdata;
			ADD:     accNext = byteT'(acc + rdata);
			SUB:     accNext = byteT'(acc - rdata);
			AND:     accNext = acc & rdata;
			default: accWrite = 1'b0;
		endcase
	end

	// Opcode and operand latched from memory
	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			opcode <= opcodeT'(rdata);
		end
		if (state == OPERAND) begin
			operand <= rdata;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= HALTED;
			pc    <= 8'h00;
			acc   <= 8'h00;
			zero  <= 1'b0;
		end else begin
			case (state)
				HALTED: begin
					if (start) begin
						state <= FETCH;
						pc    <= 8'h00;
					end
				end
				FETCH: state <= OPERAND;
				OPERAND: state <= EXECUTE;
				EXECUTE: begin
					if (accWrite) begin
						acc  <= accNext;
						zero <= (accNext == 8'h00);
					end
					case (opcode)
						LDI, LDA, STA, ADD, SUB, AND: begin
							pc    <= addrT'(pc + 8'd2);
							state <= FETCH;
						end
						JMP: begin
							pc    <= operand;
							state <= FETCH;
						end
						JZ: begin
							pc    <= zero ? operand : addrT'(pc + 8'd2);
							state <= FETCH;
						end
						// HLT and unknown opcodes stop the core
						default: state <= HALTED;
					endcase
				end
				default: state <= HALTED;
			endcase
		end
	end

	stateLegal: assert property (
		@(posedge clk) disable iff (!nRst)
		!$isunknown(state) && (state inside {HALTED, FETCH, OPERAND, EXECUTE})
	) else $error("core state illegal");

	// Stores come only from EXECUTE and the core then fetches the next instruction
	writeOnlyInExecute: assert property (
		@(posedge clk) disable iff (!nRst)
		coreReq.we |-> (state == EXECUTE) ##1 (state == FETCH)
	) else $error("core write outside EXECUTE");

endmodule

/* hdl/apbHostPort.sv */
`timescale 1ns/1ps

module apbHostPort import upPkg::*; (
	input  logic   clk,
	input  logic   nRst,
	input  apbReqT apbReq,
	output apbRspT apbRsp,
	input  logic   halted,
	input  byteT   acc,
	input  logic   zero,
	input  addrT   pc,
	input  byteT   rdata,
	output memReqT hostReq,
	output logic   hostOwn,
	output logic   start
);

	logic        access;
	logic        memWin;
	logic        isCtrl;
	logic        isStatus;
	logic [31:0] statusWord;

	assign access   = apbReq.psel & apbReq.penable;
	assign memWin   = ~apbReq.paddr[8];
	assign isCtrl   = (apbReq.paddr == regAddrCtrl);
	assign isStatus = (apbReq.paddr == regAddrStatus);

	assign statusWord = {8'h00, pc, acc, 6'b0, zero, halted};

	assign hostOwn = halted;

	// Memory writes land at the edge ending the access cycle
	assign hostReq.addr  = apbReq.paddr[7:0];
	assign hostReq.wdata = apbReq.pwdata[7:0];
	assign hostReq.we    = access & apbReq.pwrite & memWin & halted;

	assign start = access & apbReq.pwrite & isCtrl & apbReq.pwdata[0] & halted;

	assign apbRsp.pready = 1'b1;

	// Memory is locked while running, and holes in the map fault
	assign apbRsp.pslverr = access & ((memWin & ~halted) | (~memWin & ~isCtrl & ~isStatus));

	always_comb begin
		apbRsp.prdata = 32'h0;
		if (access && !apbReq.pwrite) begin
			if (memWin) begin
				if (halted) begin
					apbRsp.prdata = {24'h0, rdata};
				end
			end else if (isStatus) begin
				apbRsp.prdata = statusWord;
			end
		end
	end

	// A faulting access cycle has no side effect on memory or the core
	errOnlyInAccess: assert property (
		@(posedge clk) disable iff (!nRst)
		apbRsp.pslverr |-> (apbReq.psel && apbReq.penable) && !hostReq.we && !start
	) else $error("pslverr outside access cycle");

	// A start pulse must find the core halted, and the core leaves HALTED next
	startOnlyWhenHalted: assert property (
		@(posedge clk) disable iff (!nRst)
		start |-> halted ##1 !halted
	) else $error("start while core running");

endmodule

/* hdl/upSystem.sv */
`timescale 1ns/1ps

module upSystem import upPkg::*; #(
	parameter addrT portAddr = 8'd127
) (
	input  logic   clk,
	input  logic   nRst,
	input  apbReqT apbReq,
	output apbRspT apbRsp,
	output byteT   portOut
);

	memReqT hostReq;
	memReqT coreReq;
	logic   hostOwn;
	logic   start;
	logic   halted;
	logic   zero;
	byteT   acc;
	byteT   rdata;
	addrT   pc;

	apbHostPort uHost (
		.clk     (clk),
		.nRst    (nRst),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.halted  (halted),
		.acc     (acc),
		.zero    (zero),
		.pc      (pc),
		.rdata   (rdata),
		.hostReq (hostReq),
		.hostOwn (hostOwn),
		.start   (start)
	);

	upCore uCore (
		.clk     (clk),
		.nRst    (nRst),
		.start   (start),
		.rdata   (rdata),
		.coreReq (coreReq),
		.halted  (halted),
		.acc     (acc),
		.zero    (zero),
		.pc      (pc)
	);

	upMemory #(
		.portAddr (portAddr)
	) uMem (
		.clk     (clk),
		.nRst    (nRst),
		.hostReq (hostReq),
		.coreReq (coreReq),
		.hostOwn (hostOwn),
		.rdata   (rdata),
		.portOut (portOut)
	);

endmodule

/* dv/upSystemTb.sv */
`timescale 1ns/1ps

module upSystemTb import upPkg::*; ();

	localparam addrT portAddr = 8'd127;
	localparam int numRows = 7;

	// One program run with its expected end state
	typedef struct packed {
		logic            load;
		logic [0:7][7:0] prog;
		byteT            d0;
		byteT            d1;
		byteT            expAcc;
		logic            expZero;
		logic            chkPort;
		byteT            expPort;
		logic            probe;
		logic            expErr;
	} rowT;

	logic   clk;
	logic   nRst;
	apbReqT apbReq;
	apbRspT apbRsp;
	byteT   portOut;

	rowT   rows [numRows];
	string names [numRows];

	upSystem #(
		.portAddr (portAddr)
	) DUT (
		.clk     (clk),
		.nRst    (nRst),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.portOut (portOut)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			failRun($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, exp, got));
		end
	endtask

	// Setup and access cycle with the response sampled mid-cycle before the closing edge
	task automatic apbTransfer(input logic wr, input logic [8:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(negedge clk);
		apbReq.psel    = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite  = wr;
		apbReq.paddr   = addr;
		apbReq.pwdata  = wdata;
		@(negedge clk);
		apbReq.penable = 1'b1;
		#1;
		checkValue("pready", 32'(1'b1), 32'(apbRsp.pready));
		rdata = apbRsp.prdata;
		err   = apbRsp.pslverr;
		@(negedge clk);
		apbReq.psel    = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	task automatic hostWrite(input string name, input logic [8:0] addr, input byteT data,
			input logic expErr);
		logic [31:0] rd;
		logic        err;
		apbTransfer(1'b1, addr, {24'h0, data}, rd, err);
		checkValue({name, " pslverr"}, 32'(expErr), 32'(err));
	endtask

	task automatic hostRead(input string name, input logic [8:0] addr, input logic expErr,
			output logic [31:0] data);
		logic err;
		apbTransfer(1'b0, addr, 32'h0, data, err);
		checkValue({name, " pslverr"}, 32'(expErr), 32'(err));
	endtask

	task automatic setArith(input int i, input string name, input byteT op, input byteT a,
			input byteT b, input byteT result);
		names[i]        = name;
		rows[i]         = '0;
		rows[i].load    = 1'b1;
		rows[i].prog    = {LDA, 8'h80, op, 8'h81, STA, portAddr, HLT, 8'h00};
		rows[i].d0      = a;
		rows[i].d1      = b;
		rows[i].expAcc  = result;
		rows[i].expZero = (result == 8'h00);
		rows[i].chkPort = 1'b1;
		rows[i].expPort = result;
	endtask

	task automatic buildTable();
		byteT a;
		byteT b;
		names[0]        = "boot image";
		rows[0]         = '0;
		rows[0].expAcc  = 8'h5A;
		rows[0].chkPort = 1'b1;
		rows[0].expPort = 8'h5A;
		a = byteT'($urandom);
		b = byteT'($urandom);
		setArith(1, "add", ADD, a, b, a + b);
		a = byteT'($urandom);
		b = byteT'($urandom);
		setArith(2, "sub", SUB, a, b, a - b);
		a = byteT'($urandom);
		b = byteT'($urandom);
		setArith(3, "and", AND, a, b, a & b);
		// A missed jump runs LDI 0x11 and halts before reaching LDI 0x33
		// JZ target is LDI 0x33 placed in the data bytes at 0x80
		names[4]       = "jz taken";
		rows[4]        = '0;
		rows[4].load   = 1'b1;
		rows[4].prog   = {LDI, 8'h00, JZ, 8'h80, LDI, 8'h11, HLT, 8'h00};
		rows[4].d0     = LDI;
		rows[4].d1     = 8'h33;
		rows[4].expAcc = 8'h33;
		names[5]       = "jmp";
		rows[5]        = '0;
		rows[5].load   = 1'b1;
		rows[5].prog   = {JMP, 8'h06, LDI, 8'h11, HLT, 8'h00, LDI, 8'h33};
		rows[5].expAcc = 8'h33;
		// Counts 0x80 up by 4 until it wraps to zero after about 290 cycles of run time
		names[6]        = "host lockout";
		rows[6]         = '0;
		rows[6].load    = 1'b1;
		rows[6].prog    = {LDA, 8'h80, ADD, 8'h81, JZ, 8'h08, JMP, 8'h02};
		rows[6].d0      = 8'h80;
		rows[6].d1      = 8'h04;
		rows[6].expZero = 1'b1;
		rows[6].probe   = 1'b1;
		rows[6].expErr  = 1'b1;
	endtask

	task automatic runRow(input int i);
		rowT         r;
		logic [31:0] status;
		logic [31:0] rd;
		r = rows[i];
		if (r.load) begin
			for (int k = 0; k < 8; k++) begin
				hostWrite(names[i], 9'(k), r.prog[k], 1'b0);
			end
			// Opcode 0x00 is unknown, so running off the end halts the core
			hostWrite(names[i], 9'h008, 8'h00, 1'b0);
			hostWrite(names[i], 9'h080, r.d0, 1'b0);
			hostWrite(names[i], 9'h081, r.d1, 1'b0);
		end
		hostWrite({names[i], " start"}, regAddrCtrl, 8'h01, 1'b0);
		if (r.probe) begin
			hostWrite({names[i], " write while running"}, 9'h090, 8'hA5, r.expErr);
		end
		do begin
			hostRead({names[i], " status"}, regAddrStatus, 1'b0, status);
		end while (!status[0]);
		checkValue({names[i], " acc"}, 32'(r.expAcc), 32'(status[15:8]));
		checkValue({names[i], " zero"}, 32'(r.expZero), 32'(status[1]));
		if (r.chkPort) begin
			checkValue({names[i], " portOut"}, 32'(r.expPort), 32'(portOut));
		end
		if (r.probe) begin
			hostRead({names[i], " readback"}, 9'h090, 1'b0, rd);
			checkValue({names[i], " locked byte"}, 32'h0, rd);
		end
	endtask

	task automatic checkMemWindow();
		byteT        pattern [16];
		logic [31:0] rd;
		for (int k = 0; k < 16; k++) begin
			pattern[k] = byteT'($urandom);
			hostWrite("memory window", 9'h0C0 + 9'(k), pattern[k], 1'b0);
		end
		for (int k = 0; k < 16; k++) begin
			hostRead("memory window", 9'h0C0 + 9'(k), 1'b0, rd);
			checkValue("memory window data", {24'h0, pattern[k]}, rd);
		end
	endtask

	initial begin
		logic [31:0] rd;
		void'($urandom(32'h916017cd));
		apbReq = '0;
		nRst   = 1'b0;
		buildTable();
		repeat (4) @(posedge clk);
		@(negedge clk);
		nRst = 1'b1;
		for (int i = 0; i < numRows; i++) begin
			runRow(i);
		end
		checkMemWindow();
		hostRead("unmapped register read", 9'h108, 1'b1, rd);
		hostWrite("unmapped register write", 9'h1FC, 8'h01, 1'b1);
		$display("TEST PASS");
		$finish;
	end

	initial begin
		repeat (numRows * 200) @(posedge clk);
		failRun("Timeout, the tests did not finish in the allowed number of cycles");
	end

endmodule

/* vlog.f */
common/upPkg.sv
hdl/upMemory.sv
core/upCore.sv
hdl/apbHostPort.sv
hdl/upSystem.sv
dv/upSystemTb.sv

/* Makefile */
TOP             ?= upSystemTb
BUILD_DIR       ?= build
FILELIST        ?= vlog.f
LOG             ?= $(BUILD_DIR)/sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BINARY)
	$(BINARY) 2>&1 | tee $(LOG)

check: run
	@grep -q "TEST PASS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)
